// ==== files.f ====
verilog/priv_pkg.sv
verilog/priv_exec.sv
verilog/csr_file.sv
verilog/tlb_array.sv
verilog/priv_top.sv
tb/tb_priv_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_priv_top -o tb_priv_top &&
./obj_dir/tb_priv_top | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "run.sh: simulation passed" ||
{
    echo "run.sh: simulation failed"
    exit 1
}

// ==== tb/tb_priv_top.sv ====
`timescale 1ns/1ps
module tb_priv_top;
    import priv_pkg::*;

    typedef enum logic [2:0] {
        K_CSR,
        K_ERTN,
        K_TLB,
        K_ICACHE,
        K_DCACHE,
        K_IDLE
    } kind_e;

    typedef struct packed {
        kind_e      kind;
        priv_req_t  req;
        logic       chk_rd;
        word_t      exp_rd;
        logic       chk_era;
        word_t      exp_era;
        word_t      exp_vaddr;
        logic [1:0] exp_type;
    } row_t;

    localparam word_t INS_TLBSRCH = 32'h0648_2800;
    localparam word_t INS_TLBRD   = 32'h0648_2c00;
    localparam word_t INS_TLBWR   = 32'h0648_3000;
    localparam word_t INS_TLBFILL = 32'h0648_3400;
    localparam word_t INS_INVTLB  = 32'h0649_8000;

    logic       clk;
    logic       rstn;
    logic       issue_valid;
    priv_req_t  issue;
    logic       issue_ready;
    logic       done;
    word_t      rd_value;
    word_t      ertn_target;
    logic [1:0] cacop_ins_type;
    word_t      cacop_vaddr;
    logic       cacop_i_en;
    logic       cacop_d_en;
    logic       cacop_i_ready;
    logic       cacop_d_ready;
    logic       cacop_i_done;
    logic       cacop_d_done;
    logic       i_idle;
    logic       d_idle;
    logic       block_cache;
    logic       block_clock;

    row_t   rows [$];
    int     errors = 0;
    integer seed = 42;

    priv_top #(
        .TLB_ENTRIES (8)
    ) i_dut (
        .clk            (clk),
        .rstn           (rstn),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .done           (done),
        .rd_value       (rd_value),
        .ertn_target    (ertn_target),
        .cacop_ins_type (cacop_ins_type),
        .cacop_vaddr    (cacop_vaddr),
        .cacop_i_en     (cacop_i_en),
        .cacop_d_en     (cacop_d_en),
        .cacop_i_ready  (cacop_i_ready),
        .cacop_d_ready  (cacop_d_ready),
        .cacop_i_done   (cacop_i_done),
        .cacop_d_done   (cacop_d_done),
        .i_idle         (i_idle),
        .d_idle         (d_idle),
        .block_cache    (block_cache),
        .block_clock    (block_clock)
    );

    always #50 clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0d ns: %s expected %08h got %08h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0d ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    function automatic row_t csr_row(input csr_addr_t num, input logic [4:0] rj_f,
                                     input word_t rj_v, input word_t rk_v,
                                     input logic chk, input word_t exp);
        row_t r;
        r                 = '0;
        r.kind            = K_CSR;
        r.req.ins         = {8'h04, num, rj_f, 5'd4};
        r.req.rj_data     = rj_v;
        r.req.rk_data     = rk_v;
        r.req.uop[UOP_CSR] = 1'b1;
        r.chk_rd          = chk;
        r.exp_rd          = exp;
        return r;
    endfunction

    function automatic row_t csrwr_row(input csr_addr_t num, input word_t val,
                                       input logic chk, input word_t old);
        return csr_row(num, 5'd1, '0, val, chk, old);
    endfunction

    function automatic row_t csrrd_row(input csr_addr_t num, input word_t exp);
        return csr_row(num, 5'd0, '0, '0, 1'b1, exp);
    endfunction

    function automatic row_t csrxchg_row(input csr_addr_t num, input word_t mask,
                                         input word_t val, input word_t old);
        return csr_row(num, 5'd5, mask, val, 1'b1, old);
    endfunction

    function automatic row_t cache_row(input logic dside, input logic [1:0] op_type,
                                       input logic [11:0] imm, input word_t base,
                                       input word_t exp_va);
        row_t r;
        r                    = '0;
        r.kind               = dside ? K_DCACHE : K_ICACHE;
        r.req.ins            = {10'h018, imm, 5'd3, op_type, 2'b00, dside};
        r.req.rj_data        = base;
        r.req.uop[UOP_CACHE] = 1'b1;
        r.exp_vaddr          = exp_va;
        r.exp_type           = op_type;
        return r;
    endfunction

    function automatic row_t tlb_row(input word_t ins, input word_t rj_v, input word_t rk_v);
        row_t r;
        r                  = '0;
        r.kind             = K_TLB;
        r.req.ins          = ins;
        r.req.rj_data      = rj_v;
        r.req.rk_data      = rk_v;
        r.req.uop[UOP_TLB] = 1'b1;
        return r;
    endfunction

    function automatic row_t ertn_row(input word_t era);
        row_t r;
        r                   = '0;
        r.kind              = K_ERTN;
        r.req.ins           = 32'h0648_3800;
        r.req.uop[UOP_ERTN] = 1'b1;
        r.chk_era           = 1'b1;
        r.exp_era           = era;
        return r;
    endfunction

    function automatic row_t idle_row();
        row_t r;
        r                   = '0;
        r.kind              = K_IDLE;
        r.req.ins           = 32'h0648_8000;
        r.req.uop[UOP_IDLE] = 1'b1;
        return r;
    endfunction

    function automatic int fixed_latency(input kind_e k);
        case (k)
            K_CSR, K_ERTN: return 1;
            K_TLB:         return 2;
            default:       return 0;  // set by the cache model
        endcase
    endfunction

    task automatic build_table;
        rows.push_back(csrwr_row(CSR_SAVE0, 32'hdead_beef, 1'b0, '0));  // save0 not reset
        rows.push_back(csrrd_row(CSR_SAVE0, 32'hdead_beef));
        rows.push_back(csrxchg_row(CSR_SAVE0, 32'h0000_ffff, 32'h1234_5678, 32'hdead_beef));
        rows.push_back(csrrd_row(CSR_SAVE0, 32'hdead_5678));
        rows.push_back(csrwr_row(CSR_CRMD, 32'hffff_ffff, 1'b1, 32'h0));
        rows.push_back(csrrd_row(CSR_CRMD, 32'h0000_0007));
        rows.push_back(csrwr_row(CSR_ASID, 32'hffff_ffff, 1'b1, 32'h0));
        rows.push_back(csrrd_row(CSR_ASID, 32'h0000_03ff));
        rows.push_back(csrwr_row(CSR_PRMD, 32'hffff_fff5, 1'b1, 32'h0));
        rows.push_back(csrrd_row(CSR_PRMD, 32'h0000_0005));
        rows.push_back(csrwr_row(CSR_ERA, 32'h1c00_0100, 1'b0, '0));
        rows.push_back(ertn_row(32'h1c00_0100));
        rows.push_back(csrrd_row(CSR_CRMD, 32'h0000_0005));  // restored from prmd
        rows.push_back(csrrd_row(14'h7, 32'h0));  // unimplemented
        rows.push_back(cache_row(1'b0, 2'd2, 12'hff8, 32'h1000_0000, 32'h0fff_fff8));
        rows.push_back(cache_row(1'b1, 2'd1, 12'h010, 32'h0000_2000, 32'h0000_2010));
        rows.push_back(cache_row(1'b0, 2'd0, 12'h7ff, 32'h0000_0000, 32'h0000_07ff));
        rows.push_back(cache_row(1'b1, 2'd3, 12'h800, 32'h0000_1000, 32'h0000_0800));
        rows.push_back(idle_row());
        rows.push_back(idle_row());
        rows.push_back(csrwr_row(CSR_TLBEHI, 32'h1234_5fff, 1'b1, 32'h0));
        rows.push_back(csrrd_row(CSR_TLBEHI, 32'h1234_4000));
        rows.push_back(csrwr_row(CSR_ASID, 32'h0000_00a5, 1'b1, 32'h0000_03ff));
        rows.push_back(csrwr_row(CSR_TLBIDX, 32'h0000_0003, 1'b1, 32'h0));
        rows.push_back(tlb_row(INS_TLBWR, '0, '0));
        rows.push_back(csrwr_row(CSR_TLBEHI, 32'h0, 1'b1, 32'h1234_4000));
        rows.push_back(tlb_row(INS_TLBRD, '0, '0));
        rows.push_back(csrrd_row(CSR_TLBEHI, 32'h1234_4000));
        rows.push_back(csrwr_row(CSR_TLBIDX, 32'h0, 1'b1, 32'h0000_0003));
        rows.push_back(tlb_row(INS_TLBSRCH, '0, '0));
        rows.push_back(csrrd_row(CSR_TLBIDX, 32'h0000_0003));  // hit at 3
        rows.push_back(tlb_row(INS_INVTLB | 32'd5, 32'h0000_00a5, 32'h1234_4000));
        rows.push_back(tlb_row(INS_TLBSRCH, '0, '0));
        rows.push_back(csrrd_row(CSR_TLBIDX, 32'h8000_0003));  // miss keeps index
        rows.push_back(csrwr_row(CSR_TLBIDX, 32'h0000_0006, 1'b1, 32'h8000_0003));
        rows.push_back(tlb_row(INS_TLBFILL, '0, '0));
        rows.push_back(tlb_row(INS_TLBSRCH, '0, '0));
        rows.push_back(csrrd_row(CSR_TLBIDX, 32'h0));  // fill pointer started at 0
    endtask

    task automatic wait_issue_ready(input int n);
        int k;
        k = 0;
        @(negedge clk);
        while (issue_ready !== 1'b1 && k < 20)
        begin
            @(negedge clk);
            k++;
        end
        if (issue_ready !== 1'b1)
        begin
            errors++;
            $display("row %0d: issue_ready stayed low for %0d cycles", n, k);
        end
    endtask

    task automatic run_row(input int n);
        row_t r;
        int   lat;
        int   cyc;
        logic fin;
        logic both_idle;
        r         = rows[n];
        lat       = fixed_latency(r.kind);
        cyc       = 0;
        fin       = 1'b0;
        both_idle = 1'b0;
        wait_issue_ready(n);
        @(posedge clk);
        issue       <= r.req;
        issue_valid <= 1'b1;
        @(negedge clk);
        check_bit("issue_ready", issue_ready, 1'b1);
        if (r.kind == K_IDLE)
            check_bit("block_cache", block_cache, 1'b1);  // rises in issue cycle
        @(posedge clk);
        issue_valid <= 1'b0;
        issue       <= '0;
        while (!fin && cyc < 30)
        begin
            @(negedge clk);
            cyc++;
            check_bit("issue_ready", issue_ready, 1'b0);
            case (r.kind)
                K_ICACHE:
                begin
                    check_bit("cacop_d_en", cacop_d_en, 1'b0);
                    check_word("cacop_vaddr", cacop_vaddr, r.exp_vaddr);
                    check_word("cacop_ins_type", {30'b0, cacop_ins_type}, {30'b0, r.exp_type});
                    if (done)
                        check_bit("cacop_i_done", cacop_i_done, 1'b1);
                end
                K_DCACHE:
                begin
                    check_bit("cacop_i_en", cacop_i_en, 1'b0);
                    check_word("cacop_vaddr", cacop_vaddr, r.exp_vaddr);
                    check_word("cacop_ins_type", {30'b0, cacop_ins_type}, {30'b0, r.exp_type});
                    if (done)
                        check_bit("cacop_d_done", cacop_d_done, 1'b1);
                end
                K_IDLE:
                begin
                    // idle state follows the cycle with both caches idle
                    check_bit("block_cache", block_cache, 1'b1);
                    check_bit("block_clock", block_clock, both_idle);
                    check_bit("done", done, both_idle);
                    both_idle = i_idle & d_idle;
                end
                default:
                    check_bit("done", done, cyc == lat);
            endcase
            if (lat != 0)
                fin = (cyc == lat);
            else
                fin = (done === 1'b1);
        end
        if (!fin)
        begin
            errors++;
            $display("row %0d: no done within %0d cycles", n, cyc);
        end
        else
        begin
            if (r.chk_rd)
                check_word("rd_value", rd_value, r.exp_rd);
            if (r.chk_era)
                check_word("ertn_target", ertn_target, r.exp_era);
        end
    endtask

    task automatic serve_cache(input logic dside);
        int dr;
        int dn;
        dr = $unsigned($random(seed)) % 4;
        dn = $unsigned($random(seed)) % 4;
        repeat (dr)
        begin
            @(negedge clk);
            if (dside)
                check_bit("cacop_d_en", cacop_d_en, 1'b1);  // held until ready
            else
                check_bit("cacop_i_en", cacop_i_en, 1'b1);
        end
        @(posedge clk);
        if (dside)
            cacop_d_ready <= 1'b1;
        else
            cacop_i_ready <= 1'b1;
        @(posedge clk);
        cacop_i_ready <= 1'b0;
        cacop_d_ready <= 1'b0;
        repeat (dn) @(posedge clk);
        if (dside)
            cacop_d_done <= 1'b1;
        else
            cacop_i_done <= 1'b1;
        @(posedge clk);
        cacop_i_done <= 1'b0;
        cacop_d_done <= 1'b0;
    endtask

    task automatic serve_idle;
        int di;
        int dd;
        int k;
        di = 1 + $unsigned($random(seed)) % 4;
        dd = 1 + $unsigned($random(seed)) % 4;
        @(posedge clk);
        i_idle <= 1'b0;
        d_idle <= 1'b0;
        for (k = 1; k <= di || k <= dd; k++)
        begin
            @(posedge clk);
            if (k == di)
                i_idle <= 1'b1;
            if (k == dd)
                d_idle <= 1'b1;
        end
        do
            @(negedge clk);
        while (block_cache);
    endtask

    initial
    begin : cache_responder
        forever
        begin
            @(negedge clk);
            if (cacop_i_en)
                serve_cache(1'b0);
            else if (cacop_d_en)
                serve_cache(1'b1);
            else if (block_cache)
                serve_idle();
        end
    end

    initial
    begin : watchdog
        int limit;
        #1;
        limit = rows.size() * 40;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("%0d errors", errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin : main
        clk           = 1'b0;
        rstn          = 1'b0;
        issue_valid   = 1'b0;
        issue         = '0;
        cacop_i_ready = 1'b0;
        cacop_d_ready = 1'b0;
        cacop_i_done  = 1'b0;
        cacop_d_done  = 1'b0;
        i_idle        = 1'b1;
        d_idle        = 1'b1;
        build_table();
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_bit("done", done, 1'b0);
        check_bit("block_cache", block_cache, 1'b0);
        check_bit("block_clock", block_clock, 1'b0);
        check_bit("cacop_i_en", cacop_i_en, 1'b0);
        check_bit("cacop_d_en", cacop_d_en, 1'b0);
        for (int n = 0; n < rows.size(); n++)
            run_row(n);
        repeat (2) @(posedge clk);
        $display("%0d rows applied, %0d errors", rows.size(), errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== verilog/csr_file.sv ====
`timescale 1ns/1ps
module csr_file (
    input  logic                 clk,
    input  logic                 rstn,
    input  priv_pkg::csr_addr_t  csr_addr,
    input  logic                 csr_ren,
    input  logic                 csr_wen,
    input  priv_pkg::word_t      csr_wdata,
    output priv_pkg::word_t      csr_rdata,
    input  logic                 ertn_en,
    output priv_pkg::word_t      ertn_target,
    output priv_pkg::tlb_csr_t   tlb_csr,
    input  priv_pkg::tlb_upd_t   tlb_upd
);
    import priv_pkg::*;

    logic [2:0] crmd;  // ie, plv
    logic [2:0] prmd;  // pie, pplv
    word_t      era;
    word_t      save0;
    asid_t      asid;
    vppn_t      ehi_vppn;
    tlb_idx_t   tlb_idx;
    logic       tlb_ne;

    assign ertn_target = era;
    assign tlb_csr     = '{idx: tlb_idx, ne: tlb_ne, vppn: ehi_vppn, asid: asid};

    always_comb
    begin
        csr_rdata = '0;
        if (csr_ren)
        begin
            case (csr_addr)
                CSR_CRMD:   csr_rdata = {29'b0, crmd};
                CSR_PRMD:   csr_rdata = {29'b0, prmd};
                CSR_ERA:    csr_rdata = era;
                CSR_TLBIDX: csr_rdata = {tlb_ne, 28'b0, tlb_idx};
                CSR_TLBEHI: csr_rdata = {ehi_vppn, 13'b0};
                CSR_ASID:   csr_rdata = {22'b0, asid};
                CSR_SAVE0:  csr_rdata = save0;
                default:    csr_rdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            crmd     <= '0;
            prmd     <= '0;
            asid     <= '0;
            ehi_vppn <= '0;
            tlb_idx  <= '0;
            tlb_ne   <= 1'b0;
        end
        else
        begin
            if (ertn_en)
                crmd <= prmd;  // restore plv and ie
            if (csr_wen)
            begin
                case (csr_addr)
                    CSR_CRMD:   crmd     <= csr_wdata[2:0];
                    CSR_PRMD:   prmd     <= csr_wdata[2:0];
                    CSR_ASID:   asid     <= csr_wdata[9:0];
                    CSR_TLBEHI: ehi_vppn <= csr_wdata[31:13];
                    CSR_TLBIDX:
                    begin
                        tlb_idx <= csr_wdata[2:0];
                        tlb_ne  <= csr_wdata[31];
                    end
                    default: ;
                endcase
            end
            // tlb result wins over a write
            if (tlb_upd.idx_we)
            begin
                tlb_idx <= tlb_upd.idx;
                tlb_ne  <= tlb_upd.ne;
            end
            if (tlb_upd.ehi_we)
            begin
                ehi_vppn <= tlb_upd.vppn;
                asid     <= tlb_upd.asid;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (csr_wen && csr_addr == CSR_ERA)
            era <= csr_wdata;
        if (csr_wen && csr_addr == CSR_SAVE0)
            save0 <= csr_wdata;
    end

endmodule

// ==== verilog/priv_exec.sv ====
`timescale 1ns/1ps
module priv_exec (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 issue_valid,
    input  priv_pkg::priv_req_t  issue,
    output logic                 issue_ready,
    output logic                 done,
    output priv_pkg::word_t      rd_value,

    output priv_pkg::csr_addr_t  csr_addr,
    output priv_pkg::word_t      csr_wdata,
    output logic                 csr_wen,
    output logic                 csr_ren,
    input  priv_pkg::word_t      csr_rdata,
    output logic                 ertn_en,

    output logic [1:0]           cacop_ins_type,
    output priv_pkg::word_t      cacop_vaddr,
    output logic                 cacop_i_en,
    output logic                 cacop_d_en,
    input  logic                 cacop_i_ready,
    input  logic                 cacop_d_ready,
    input  logic                 cacop_i_done,
    input  logic                 cacop_d_done,

    input  logic                 i_idle,
    input  logic                 d_idle,
    output logic                 block_cache,
    output logic                 block_clock,

    output logic                 tlb_valid,
    output priv_pkg::tlb_op_e    tlb_op,
    output priv_pkg::invtlb_t    tlb_inv,
    input  logic                 tlb_ready
);
    import priv_pkg::*;

    priv_state_e state, state_nx;
    priv_req_t   req_q;
    priv_req_t   req;
    word_t       rd_q;
    logic        accept;
    logic [4:0]  rj;
    logic        is_xchg;
    logic        is_icache;
    logic        is_dcache;
    word_t       imm_ext;

    assign issue_ready = (state == ST_INIT);
    assign accept      = issue_valid & issue_ready;
    assign req         = (state == ST_INIT) ? issue : req_q;  // live bundle until taken

    assign rj        = req.ins[9:5];
    assign is_xchg   = |rj[4:1];  // rj of 1 is csrwr
    assign is_icache = req.uop[UOP_CACHE] & (req.ins[2:0] == 3'b000);
    assign is_dcache = req.uop[UOP_CACHE] & (req.ins[2:0] == 3'b001);
    assign imm_ext   = {{20{req.ins[21]}}, req.ins[21:10]};

    assign csr_addr       = req.ins[23:10];
    assign rd_value       = rd_q;
    assign cacop_ins_type = req.ins[4:3];
    assign cacop_vaddr    = req.rj_data + imm_ext;
    assign tlb_inv        = '{op: req.ins[4:0], asid: req.rj_data[9:0],
                              vppn: req.rk_data[31:13]};

    always_comb
    begin
        if (req.ins[16])
            tlb_op = TLB_INV;
        else
        begin
            case (req.ins[11:10])
                2'b10:   tlb_op = TLB_SRCH;
                2'b11:   tlb_op = TLB_RD;
                2'b00:   tlb_op = TLB_WR;
                default: tlb_op = TLB_FILL;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state <= ST_INIT;
        else
            state <= state_nx;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_q <= issue;
            if (issue.uop[UOP_CSR])
                rd_q <= csr_rdata;  // old value for rd and xchg
        end
    end

    always_comb
    begin
        state_nx = state;
        case (state)
            ST_INIT:
            begin
                if (accept)
                begin
                    if (req.uop[UOP_CSR])
                        state_nx = ST_CSR;
                    else if (is_icache)
                        state_nx = ST_CACOP_I_CALL;
                    else if (is_dcache)
                        state_nx = ST_CACOP_D_CALL;
                    else if (req.uop[UOP_ERTN])
                        state_nx = ST_ERTN;
                    else if (req.uop[UOP_IDLE])
                        state_nx = ST_IDLE_WAIT;
                    else if (req.uop[UOP_TLB])
                        state_nx = ST_TLB_WAIT;
                end
            end
            ST_CACOP_I_CALL:
            begin
                if (cacop_i_ready)
                    state_nx = ST_CACOP_I_WAIT;
            end
            ST_CACOP_I_WAIT:
            begin
                if (cacop_i_done)
                    state_nx = ST_INIT;
            end
            ST_CACOP_D_CALL:
            begin
                if (cacop_d_ready)
                    state_nx = ST_CACOP_D_WAIT;
            end
            ST_CACOP_D_WAIT:
            begin
                if (cacop_d_done)
                    state_nx = ST_INIT;
            end
            ST_IDLE_WAIT:
            begin
                if (i_idle & d_idle)
                    state_nx = ST_IDLE;
            end
            ST_TLB_WAIT:
            begin
                if (tlb_ready)
                    state_nx = ST_INIT;
            end
            default:
                state_nx = ST_INIT;  // csr, ertn, idle take one cycle
        endcase
    end

    always_comb
    begin
        csr_ren     = 1'b0;
        csr_wen     = 1'b0;
        csr_wdata   = '0;
        ertn_en     = 1'b0;
        block_cache = 1'b0;
        block_clock = 1'b0;
        tlb_valid   = 1'b0;
        done        = 1'b0;
        cacop_i_en  = (state == ST_CACOP_I_CALL);
        cacop_d_en  = (state == ST_CACOP_D_CALL);
        case (state)
            ST_INIT:
            begin
                csr_ren     = accept & req.uop[UOP_CSR];
                ertn_en     = accept & ~req.uop[UOP_CSR] & req.uop[UOP_ERTN];
                block_cache = accept & req.uop[UOP_IDLE];
                tlb_valid   = accept & req.uop[UOP_TLB];
            end
            ST_CSR:
            begin
                csr_ren   = 1'b1;
                csr_wen   = |rj;  // csrrd has rj zero
                csr_wdata = is_xchg ? ((rd_q & ~req.rj_data) | (req.rk_data & req.rj_data))
                                    : req.rk_data;
                done      = 1'b1;
            end
            ST_CACOP_I_WAIT:
                done = cacop_i_done;
            ST_CACOP_D_WAIT:
                done = cacop_d_done;
            ST_ERTN:
                done = 1'b1;
            ST_IDLE_WAIT:
                block_cache = 1'b1;
            ST_IDLE:
            begin
                block_cache = 1'b1;
                block_clock = 1'b1;
                done        = 1'b1;
            end
            ST_TLB_WAIT:
                done = tlb_ready;
            default:
                done = 1'b0;
        endcase
    end

    // no completion while waiting for a request
    a_no_done_in_init: assert property (@(posedge clk) disable iff (!rstn)
        (state == ST_INIT) |-> !done);

    a_one_cache: assert property (@(posedge clk) disable iff (!rstn)
        !(cacop_i_en && cacop_d_en));

endmodule

// ==== verilog/priv_pkg.sv ====
package priv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [18:0] vppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [2:0]  tlb_idx_t;
    typedef logic [4:0]  uop_t;

    // one-hot uop bit positions
    localparam int UOP_CSR   = 0;  // csrrd/csrwr/csrxchg
    localparam int UOP_CACHE = 1;  // cacop
    localparam int UOP_ERTN  = 2;  // exception return
    localparam int UOP_IDLE  = 3;  // wait for idle
    localparam int UOP_TLB   = 4;  // tlb maintenance

    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_TLBIDX = 14'h10;
    localparam csr_addr_t CSR_TLBEHI = 14'h11;
    localparam csr_addr_t CSR_ASID   = 14'h18;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;

    typedef enum logic [2:0] {
        TLB_SRCH,
        TLB_RD,
        TLB_WR,
        TLB_FILL,
        TLB_INV
    } tlb_op_e;

    typedef enum logic [3:0] {
        ST_INIT,
        ST_CSR,
        ST_CACOP_I_CALL,
        ST_CACOP_I_WAIT,
        ST_CACOP_D_CALL,
        ST_CACOP_D_WAIT,
        ST_ERTN,
        ST_IDLE_WAIT,
        ST_IDLE,
        ST_TLB_WAIT
    } priv_state_e;

    typedef struct packed {
        word_t ins;
        word_t rj_data;
        word_t rk_data;
        uop_t  uop;
    } priv_req_t;

    typedef struct packed {
        tlb_idx_t idx;
        logic     ne;
        vppn_t    vppn;
        asid_t    asid;
    } tlb_csr_t;

    typedef struct packed {
        logic     idx_we;  // index and ne
        logic     ehi_we;  // vppn and asid
        tlb_idx_t idx;
        logic     ne;
        vppn_t    vppn;
        asid_t    asid;
    } tlb_upd_t;

    typedef struct packed {
        logic [4:0] op;
        asid_t      asid;
        vppn_t      vppn;
    } invtlb_t;

endpackage

// ==== verilog/priv_top.sv ====
`timescale 1ns/1ps
module priv_top #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 issue_valid,
    input  priv_pkg::priv_req_t  issue,
    output logic                 issue_ready,
    output logic                 done,
    output priv_pkg::word_t      rd_value,
    output priv_pkg::word_t      ertn_target,
    output logic [1:0]           cacop_ins_type,
    output priv_pkg::word_t      cacop_vaddr,
    output logic                 cacop_i_en,
    output logic                 cacop_d_en,
    input  logic                 cacop_i_ready,
    input  logic                 cacop_d_ready,
    input  logic                 cacop_i_done,
    input  logic                 cacop_d_done,
    input  logic                 i_idle,
    input  logic                 d_idle,
    output logic                 block_cache,
    output logic                 block_clock
);
    import priv_pkg::*;

    csr_addr_t csr_addr;
    word_t     csr_wdata;
    word_t     csr_rdata;
    logic      csr_wen;
    logic      csr_ren;
    logic      ertn_en;
    logic      tlb_valid;
    logic      tlb_ready;
    tlb_op_e   tlb_op;
    invtlb_t   tlb_inv;
    tlb_csr_t  tlb_csr;
    tlb_upd_t  tlb_upd;

    priv_exec i_exec (
        .clk            (clk),
        .rstn           (rstn),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .done           (done),
        .rd_value       (rd_value),
        .csr_addr       (csr_addr),
        .csr_wdata      (csr_wdata),
        .csr_wen        (csr_wen),
        .csr_ren        (csr_ren),
        .csr_rdata      (csr_rdata),
        .ertn_en        (ertn_en),
        .cacop_ins_type (cacop_ins_type),
        .cacop_vaddr    (cacop_vaddr),
        .cacop_i_en     (cacop_i_en),
        .cacop_d_en     (cacop_d_en),
        .cacop_i_ready  (cacop_i_ready),
        .cacop_d_ready  (cacop_d_ready),
        .cacop_i_done   (cacop_i_done),
        .cacop_d_done   (cacop_d_done),
        .i_idle         (i_idle),
        .d_idle         (d_idle),
        .block_cache    (block_cache),
        .block_clock    (block_clock),
        .tlb_valid      (tlb_valid),
        .tlb_op         (tlb_op),
        .tlb_inv        (tlb_inv),
        .tlb_ready      (tlb_ready)
    );

    csr_file i_csr (
        .clk         (clk),
        .rstn        (rstn),
        .csr_addr    (csr_addr),
        .csr_ren     (csr_ren),
        .csr_wen     (csr_wen),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .ertn_en     (ertn_en),
        .ertn_target (ertn_target),
        .tlb_csr     (tlb_csr),
        .tlb_upd     (tlb_upd)
    );

    tlb_array #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_tlb (
        .clk       (clk),
        .rstn      (rstn),
        .tlb_valid (tlb_valid),
        .tlb_op    (tlb_op),
        .tlb_inv   (tlb_inv),
        .tlb_csr   (tlb_csr),
        .tlb_ready (tlb_ready),
        .tlb_upd   (tlb_upd)
    );

endmodule

// ==== verilog/tlb_array.sv ====
`timescale 1ns/1ps
module tlb_array #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 tlb_valid,
    input  priv_pkg::tlb_op_e    tlb_op,
    input  priv_pkg::invtlb_t    tlb_inv,
    input  priv_pkg::tlb_csr_t   tlb_csr,
    output logic                 tlb_ready,
    output priv_pkg::tlb_upd_t   tlb_upd
);
    import priv_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [TLB_ENTRIES-1:0] ent_v;
    vppn_t                  ent_vppn [TLB_ENTRIES];
    asid_t                  ent_asid [TLB_ENTRIES];
    logic [IDX_W-1:0]       fill_ptr;
    logic [1:0]             stage;
    tlb_op_e                op_q;
    invtlb_t                inv_q;
    logic [IDX_W-1:0]       csr_idx;
    logic [IDX_W-1:0]       wr_idx;
    logic                   wr_en;
    logic                   hit;
    tlb_idx_t               hit_idx;
    logic [TLB_ENTRIES-1:0] inv_hit;

    assign csr_idx   = tlb_csr.idx[IDX_W-1:0];
    assign tlb_ready = stage[1];  // two cycles after valid
    assign wr_en     = tlb_ready & ((op_q == TLB_WR) | (op_q == TLB_FILL));
    assign wr_idx    = (op_q == TLB_FILL) ? fill_ptr : csr_idx;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            stage <= '0;
        else
            stage <= {stage[0], tlb_valid};
    end

    always_ff @(posedge clk)
    begin
        if (tlb_valid)
        begin
            op_q  <= tlb_op;
            inv_q <= tlb_inv;
        end
    end

    always_comb
    begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            if (!hit && ent_v[i] && ent_vppn[i] == tlb_csr.vppn && ent_asid[i] == tlb_csr.asid)
            begin
                hit     = 1'b1;
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            case (inv_q.op)
                5'd0, 5'd1: inv_hit[i] = 1'b1;
                5'd4:       inv_hit[i] = (ent_asid[i] == inv_q.asid);
                5'd5:       inv_hit[i] = (ent_asid[i] == inv_q.asid) &&
                                         (ent_vppn[i] == inv_q.vppn);
                default:    inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_comb
    begin
        tlb_upd      = '0;
        tlb_upd.idx  = tlb_csr.idx;
        tlb_upd.vppn = ent_vppn[csr_idx];
        tlb_upd.asid = ent_asid[csr_idx];
        if (tlb_ready)
        begin
            case (op_q)
                TLB_SRCH:
                begin
                    tlb_upd.idx_we = 1'b1;
                    tlb_upd.ne     = ~hit;
                    if (hit)
                        tlb_upd.idx = hit_idx;
                end
                TLB_RD:
                begin
                    tlb_upd.idx_we = 1'b1;
                    tlb_upd.ne     = ~ent_v[csr_idx];
                    tlb_upd.ehi_we = ent_v[csr_idx];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            ent_v    <= '0;
            fill_ptr <= '0;
        end
        else if (tlb_ready)
        begin
            if (wr_en)
                ent_v[wr_idx] <= ~tlb_csr.ne;
            if (op_q == TLB_FILL)
                fill_ptr <= fill_ptr + 1'b1;  // round robin
            if (op_q == TLB_INV)
                ent_v <= ent_v & ~inv_hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            ent_vppn[wr_idx] <= tlb_csr.vppn;
            ent_asid[wr_idx] <= tlb_csr.asid;
        end
    end

    // latched op is still the one being answered
    a_ready_has_op: assert property (@(posedge clk) disable iff (!rstn)
        tlb_ready |-> $past(tlb_valid, 2) && !$past(tlb_valid));

endmodule
